/* cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] insn_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Execution unit
    typedef enum logic {
        OP_ALU,
        OP_MUL
    } op_type_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // Major opcodes of the subset
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // MUL shares funct3 000 with ADD and differs only in funct7
    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_SUB    = 7'b0100000;
    localparam funct7_t F7_MULDIV = 7'b0000001;

endpackage

/* insn_decoder.sv */
`timescale 1ns/1ps

module insn_decoder import cpu_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            i_insn_valid,
    input  insn_t           i_insn,
    input  logic [XLEN-1:0] i_pc,
    input  logic            i_ready,
    output logic            o_insn_ready,
    output logic            o_valid,
    output logic [XLEN-1:0] o_pc,
    output reg_idx_t        o_rd,
    output reg_idx_t        o_rs1,
    output reg_idx_t        o_rs2,
    output logic [XLEN-1:0] o_imm,
    output logic            o_use_imm,
    output op_type_e        o_op_type,
    output alu_op_e         o_alu_op
);

    opcode_t         opcode;
    funct3_t         funct3;
    funct7_t         funct7;
    logic            accept;
    logic            dec_legal;
    reg_idx_t        dec_rd;
    reg_idx_t        dec_rs1;
    reg_idx_t        dec_rs2;
    logic [XLEN-1:0] dec_imm;
    logic            dec_use_imm;
    op_type_e        dec_op_type;
    alu_op_e         dec_alu_op;

    assign opcode = i_insn[6:0];
    assign funct3 = i_insn[14:12];
    assign funct7 = i_insn[31:25];

    assign o_insn_ready = i_ready;
    assign accept = i_insn_valid && i_ready;

    always_comb begin
        dec_legal   = 1'b1;
        dec_rd      = i_insn[11:7];
        dec_rs1     = i_insn[19:15];
        dec_rs2     = i_insn[24:20];
        dec_imm     = {{(XLEN-12){i_insn[31]}}, i_insn[31:20]};
        dec_use_imm = 1'b0;
        dec_op_type = OP_ALU;
        dec_alu_op  = ALU_ADD;
        if (opcode == OPC_OP) begin
            case ({funct7, funct3})
                {F7_BASE, F3_ADD_SUB}:   dec_alu_op = ALU_ADD;
                {F7_SUB, F3_ADD_SUB}:    dec_alu_op = ALU_SUB;
                {F7_BASE, F3_AND}:       dec_alu_op = ALU_AND;
                {F7_BASE, F3_OR}:        dec_alu_op = ALU_OR;
                {F7_BASE, F3_XOR}:       dec_alu_op = ALU_XOR;
                {F7_BASE, F3_SLT}:       dec_alu_op = ALU_SLT;
                {F7_MULDIV, F3_ADD_SUB}: dec_op_type = OP_MUL;
                default:                 dec_legal = 1'b0;
            endcase
        end else if (opcode == OPC_OP_IMM && funct3 == F3_ADD_SUB) begin
            // The rs2 field of ADDI holds immediate bits and must not raise a hazard
            dec_use_imm = 1'b1;
            dec_rs2     = '0;
        end else begin
            dec_legal = 1'b0;
        end

        // Anything else retires as ADD x0, x0, x0
        if (!dec_legal) begin
            dec_rd      = '0;
            dec_rs1     = '0;
            dec_rs2     = '0;
            dec_use_imm = 1'b0;
            dec_op_type = OP_ALU;
            dec_alu_op  = ALU_ADD;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_valid <= 1'b0;
        end else if (accept) begin
            o_valid <= 1'b1;
        end else if (o_valid && i_ready) begin
            o_valid <= 1'b0;
        end
    end

    // Selects also feed the register file read ports
    always_ff @(posedge clk) begin
        if (accept) begin
            o_pc      <= i_pc;
            o_rd      <= dec_rd;
            o_rs1     <= dec_rs1;
            o_rs2     <= dec_rs2;
            o_imm     <= dec_imm;
            o_use_imm <= dec_use_imm;
            o_op_type <= dec_op_type;
            o_alu_op  <= dec_alu_op;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!resetn)
        o_valid && !i_ready |=> o_valid &&
            $stable({o_pc, o_rd, o_rs1, o_rs2, o_imm, o_use_imm, o_op_type, o_alu_op}));

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            resetn,
    input  reg_idx_t        i_ra_sel,
    input  reg_idx_t        i_rb_sel,
    input  logic            i_w_en,
    input  reg_idx_t        i_w_sel,
    input  logic [XLEN-1:0] i_w_data,
    output logic [XLEN-1:0] o_ra_data,
    output logic [XLEN-1:0] o_rb_data
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_w_en && i_w_sel != '0) begin
            regs[i_w_sel] <= i_w_data;
        end
    end

    // x0 reads as zero
    assign o_ra_data = (i_ra_sel == '0) ? '0 : regs[i_ra_sel];
    assign o_rb_data = (i_rb_sel == '0) ? '0 : regs[i_rb_sel];

endmodule

/* issue_stage.sv */
`timescale 1ns/1ps

module issue_stage import cpu_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            i_valid,
    input  logic [XLEN-1:0] i_pc,
    input  reg_idx_t        i_rd,
    input  reg_idx_t        i_rs1,
    input  reg_idx_t        i_rs2,
    input  logic [XLEN-1:0] i_imm,
    input  logic            i_use_imm,
    input  op_type_e        i_op_type,
    input  alu_op_e         i_alu_op,
    input  logic [XLEN-1:0] i_rs1_data,
    input  logic [XLEN-1:0] i_rs2_data,
    input  logic            i_ex2_ready,
    input  logic            i_ex2_pending,
    input  logic            i_wb_valid,
    input  reg_idx_t        i_wb_rd,
    input  logic [XLEN-1:0] i_wb_data,
    output logic            o_de_ready,
    output logic            o_ex_valid,
    output logic [XLEN-1:0] o_ex_pc,
    output reg_idx_t        o_ex_rd,
    output op_type_e        o_ex_op_type,
    output logic            o_ex_value_valid,
    output logic [XLEN-1:0] o_ex_data,
    output logic [XLEN-1:0] o_ex_data2
);

    logic [XLEN:0]   rs1_res;
    logic [XLEN:0]   rs2_res;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            stalled;
    logic            ex_take;
    logic            ex_drain;

    // Returns {stall, value} with o_ex_valid as the EX pending flag
    function automatic logic [XLEN:0] resolve(reg_idx_t sel, logic [XLEN-1:0] rf_data);
        logic [XLEN-1:0] value;
        logic            stall;
        value = rf_data;
        stall = 1'b0;
        if (i_ex2_pending && i_wb_rd == sel && sel != '0) begin
            if (i_wb_valid) begin
                value = i_wb_data;
            end else begin
                stall = 1'b1;
            end
        end
        // EX holds the younger producer
        if (o_ex_valid && o_ex_rd == sel && sel != '0) begin
            value = o_ex_data;
            stall = !o_ex_value_valid;
        end
        return {stall, value};
    endfunction

    always_comb begin
        rs1_res = resolve(i_rs1, i_rs1_data);
        rs2_res = resolve(i_rs2, i_rs2_data);
    end

    assign rs1_val = rs1_res[XLEN-1:0];
    assign rs2_val = rs2_res[XLEN-1:0];
    assign stalled = i_valid && (rs1_res[XLEN] || rs2_res[XLEN]);

    assign ex_drain   = o_ex_valid && i_ex2_ready;
    assign o_de_ready = !stalled && (!o_ex_valid || i_ex2_ready);
    assign ex_take    = i_valid && o_de_ready;

    assign op_b = i_use_imm ? i_imm : rs2_val;

    always_comb begin
        case (i_alu_op)
            ALU_ADD: alu_result = rs1_val + op_b;
            ALU_SUB: alu_result = rs1_val - op_b;
            ALU_AND: alu_result = rs1_val & op_b;
            ALU_OR:  alu_result = rs1_val | op_b;
            ALU_XOR: alu_result = rs1_val ^ op_b;
            ALU_SLT: alu_result = XLEN'($signed(rs1_val) < $signed(op_b));
            default: alu_result = rs1_val + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_ex_valid       <= 1'b0;
            o_ex_value_valid <= 1'b0;
            o_ex_rd          <= '0;
        end else begin
            if (ex_drain) begin
                o_ex_valid       <= 1'b0;
                o_ex_value_valid <= 1'b0;
                o_ex_rd          <= '0;
            end
            if (ex_take) begin
                o_ex_valid       <= 1'b1;
                o_ex_value_valid <= (i_op_type == OP_ALU);
                o_ex_rd          <= i_rd;
            end
        end
    end

    // MUL carries both operands on to EX2
    always_ff @(posedge clk) begin
        if (ex_take) begin
            o_ex_pc      <= i_pc;
            o_ex_op_type <= i_op_type;
            o_ex_data    <= (i_op_type == OP_MUL) ? rs1_val : alu_result;
            o_ex_data2   <= rs2_val;
        end
    end

    // A stalled cycle may drain EX but never fills it
    a_no_issue_on_stall: assert property (@(posedge clk) disable iff (!resetn)
        stalled |=> o_ex_valid == ($past(o_ex_valid) && !$past(i_ex2_ready)));

endmodule

/* mul_unit.sv */
`timescale 1ns/1ps

module mul_unit #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            i_start,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    output logic            o_valid,
    output logic [XLEN-1:0] o_result
);

    localparam int CNT_W = $clog2(XLEN);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(XLEN - 1);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] count;
    logic [XLEN-1:0]  multiplicand;
    logic [XLEN-1:0]  multiplier;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= ST_IDLE;
            count   <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state <= ST_BUSY;
                        count <= '0;
                    end
                end
                ST_BUSY: begin
                    count <= count + 1'b1;
                    if (count == LAST) begin
                        state   <= ST_IDLE;
                        o_valid <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // One multiplier bit per cycle with o_result as the running sum
    always_ff @(posedge clk) begin
        if (i_start) begin
            o_result     <= '0;
            multiplicand <= i_a;
            multiplier   <= i_b;
        end else if (state == ST_BUSY) begin
            if (multiplier[0]) begin
                o_result <= o_result + multiplicand;
            end
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!resetn)
        i_start |-> state == ST_IDLE);

endmodule

/* commit_stage.sv */
`timescale 1ns/1ps

module commit_stage import cpu_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            i_valid,
    input  logic [XLEN-1:0] i_pc,
    input  reg_idx_t        i_rd,
    input  op_type_e        i_op_type,
    input  logic            i_value_valid,
    input  logic [XLEN-1:0] i_data,
    input  logic [XLEN-1:0] i_data2,
    output logic            o_ready,
    output logic            o_pending,
    output logic            o_wb_valid,
    output logic [XLEN-1:0] o_wb_pc,
    output reg_idx_t        o_wb_rd,
    output logic [XLEN-1:0] o_wb_data
);

    logic            ex2_take;
    logic            sel_mul;
    logic            alu_valid;
    logic [XLEN-1:0] alu_data;
    logic            mul_start;
    logic            mul_valid;
    logic [XLEN-1:0] mul_result;

    assign ex2_take  = i_valid && o_ready;
    assign mul_start = ex2_take && i_op_type == OP_MUL;

    mul_unit #(
        .XLEN (XLEN)
    ) u_mul (
        .clk      (clk),
        .resetn   (resetn),
        .i_start  (mul_start),
        .i_a      (i_data),
        .i_b      (i_data2),
        .o_valid  (mul_valid),
        .o_result (mul_result)
    );

    assign o_wb_valid = sel_mul ? mul_valid : alu_valid;
    assign o_wb_data  = sel_mul ? mul_result : alu_data;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_ready   <= 1'b1;
            o_pending <= 1'b0;
            o_wb_rd   <= '0;
            sel_mul   <= 1'b0;
            alu_valid <= 1'b0;
        end else if (ex2_take) begin
            o_ready   <= 1'b0;
            o_pending <= 1'b1;
            o_wb_rd   <= i_rd;
            sel_mul   <= (i_op_type == OP_MUL);
            alu_valid <= (i_op_type == OP_ALU) && i_value_valid;
        end else if (o_wb_valid) begin
            // Ready again in the cycle after the write-back pulse
            o_ready   <= 1'b1;
            o_pending <= 1'b0;
            o_wb_rd   <= '0;
            sel_mul   <= 1'b0;
            alu_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex2_take) begin
            o_wb_pc  <= i_pc;
            alu_data <= i_data;
        end
    end

    a_wb_pulse: assert property (@(posedge clk) disable iff (!resetn)
        o_wb_valid |=> !o_wb_valid);

endmodule

/* cpu_core.sv */
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            i_insn_valid,
    input  insn_t           i_insn,
    input  logic [XLEN-1:0] i_pc,
    output logic            o_insn_ready,
    output logic            o_commit_valid,
    output logic [XLEN-1:0] o_commit_pc,
    output reg_idx_t        o_commit_rd,
    output logic [XLEN-1:0] o_commit_data
);

    // Decode to issue
    logic            de_valid;
    logic            de_ready;
    logic [XLEN-1:0] de_pc;
    reg_idx_t        de_rd;
    reg_idx_t        de_rs1;
    reg_idx_t        de_rs2;
    logic [XLEN-1:0] de_imm;
    logic            de_use_imm;
    op_type_e        de_op_type;
    alu_op_e         de_alu_op;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    // Issue to commit
    logic            ex_valid;
    logic [XLEN-1:0] ex_pc;
    reg_idx_t        ex_rd;
    op_type_e        ex_op_type;
    logic            ex_value_valid;
    logic [XLEN-1:0] ex_data;
    logic [XLEN-1:0] ex_data2;
    logic            ex2_ready;

    // Write-back
    logic            ex2_pending;
    logic            wb_valid;
    logic [XLEN-1:0] wb_pc;
    reg_idx_t        wb_rd;
    logic [XLEN-1:0] wb_data;

    insn_decoder #(
        .XLEN (XLEN)
    ) u_decoder (
        .clk          (clk),
        .resetn       (resetn),
        .i_insn_valid (i_insn_valid),
        .i_insn       (i_insn),
        .i_pc         (i_pc),
        .i_ready      (de_ready),
        .o_insn_ready (o_insn_ready),
        .o_valid      (de_valid),
        .o_pc         (de_pc),
        .o_rd         (de_rd),
        .o_rs1        (de_rs1),
        .o_rs2        (de_rs2),
        .o_imm        (de_imm),
        .o_use_imm    (de_use_imm),
        .o_op_type    (de_op_type),
        .o_alu_op     (de_alu_op)
    );

    reg_file #(
        .XLEN (XLEN)
    ) u_reg_file (
        .clk       (clk),
        .resetn    (resetn),
        .i_ra_sel  (de_rs1),
        .i_rb_sel  (de_rs2),
        .i_w_en    (wb_valid),
        .i_w_sel   (wb_rd),
        .i_w_data  (wb_data),
        .o_ra_data (rs1_data),
        .o_rb_data (rs2_data)
    );

    issue_stage #(
        .XLEN (XLEN)
    ) u_issue (
        .clk              (clk),
        .resetn           (resetn),
        .i_valid          (de_valid),
        .i_pc             (de_pc),
        .i_rd             (de_rd),
        .i_rs1            (de_rs1),
        .i_rs2            (de_rs2),
        .i_imm            (de_imm),
        .i_use_imm        (de_use_imm),
        .i_op_type        (de_op_type),
        .i_alu_op         (de_alu_op),
        .i_rs1_data       (rs1_data),
        .i_rs2_data       (rs2_data),
        .i_ex2_ready      (ex2_ready),
        .i_ex2_pending    (ex2_pending),
        .i_wb_valid       (wb_valid),
        .i_wb_rd          (wb_rd),
        .i_wb_data        (wb_data),
        .o_de_ready       (de_ready),
        .o_ex_valid       (ex_valid),
        .o_ex_pc          (ex_pc),
        .o_ex_rd          (ex_rd),
        .o_ex_op_type     (ex_op_type),
        .o_ex_value_valid (ex_value_valid),
        .o_ex_data        (ex_data),
        .o_ex_data2       (ex_data2)
    );

    commit_stage #(
        .XLEN (XLEN)
    ) u_commit (
        .clk           (clk),
        .resetn        (resetn),
        .i_valid       (ex_valid),
        .i_pc          (ex_pc),
        .i_rd          (ex_rd),
        .i_op_type     (ex_op_type),
        .i_value_valid (ex_value_valid),
        .i_data        (ex_data),
        .i_data2       (ex_data2),
        .o_ready       (ex2_ready),
        .o_pending     (ex2_pending),
        .o_wb_valid    (wb_valid),
        .o_wb_pc       (wb_pc),
        .o_wb_rd       (wb_rd),
        .o_wb_data     (wb_data)
    );

    assign o_commit_valid = wb_valid;
    assign o_commit_pc    = wb_pc;
    assign o_commit_rd    = wb_rd;
    assign o_commit_data  = wb_data;

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import cpu_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            i_insn_valid,
    input  logic            i_insn_ready,
    input  insn_t           i_insn,
    input  logic [XLEN-1:0] i_pc,
    input  logic            i_commit_valid,
    input  logic [XLEN-1:0] i_commit_pc,
    input  reg_idx_t        i_commit_rd,
    input  logic [XLEN-1:0] i_commit_data,
    output int              o_accepted,
    output int              o_committed,
    output int              o_errors
);

    logic [XLEN-1:0] shadow [32];
    insn_t           insn_q [$];
    logic [XLEN-1:0] pc_q [$];
    int              accepted = 0;
    int              committed = 0;
    int              errors = 0;

    assign o_accepted  = accepted;
    assign o_committed = committed;
    assign o_errors    = errors;

    // RV32 subset semantics on the shadow registers
    function automatic void exec_insn(input insn_t insn, output reg_idx_t rd,
                                      output logic [XLEN-1:0] value);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        a   = shadow[insn[19:15]];
        b   = shadow[insn[24:20]];
        imm = {{(XLEN-12){insn[31]}}, insn[31:20]};
        rd  = insn[11:7];
        value = '0;
        if (insn[6:0] == OPC_OP_IMM && insn[14:12] == F3_ADD_SUB) begin
            value = a + imm;
        end else if (insn[6:0] != OPC_OP) begin
            rd = '0;
        end else begin
            case ({insn[31:25], insn[14:12]})
                {F7_BASE, F3_ADD_SUB}:   value = a + b;
                {F7_SUB, F3_ADD_SUB}:    value = a - b;
                {F7_BASE, F3_AND}:       value = a & b;
                {F7_BASE, F3_OR}:        value = a | b;
                {F7_BASE, F3_XOR}:       value = a ^ b;
                {F7_BASE, F3_SLT}:       value = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
                {F7_MULDIV, F3_ADD_SUB}: value = a * b;
                default:                 rd = '0;
            endcase
        end
    endfunction

    task automatic check_commit();
        insn_t           insn;
        logic [XLEN-1:0] pc;
        reg_idx_t        exp_rd;
        logic [XLEN-1:0] exp_data;
        logic            ok;
        committed++;
        if (insn_q.size() == 0) begin
            $display("error: extra commit at pc %h with no accepted instruction left",
                     i_commit_pc);
            errors++;
        end else begin
            insn = insn_q.pop_front();
            pc   = pc_q.pop_front();
            exec_insn(insn, exp_rd, exp_data);
            ok = 1'b1;
            if (i_commit_pc !== pc) begin
                $display("FAIL %0t: commit pc %h, expected %h", $time, i_commit_pc, pc);
                ok = 1'b0;
            end
            if (i_commit_rd !== exp_rd) begin
                $display("FAIL %0t: pc %h commit rd x%0d, expected x%0d",
                         $time, pc, i_commit_rd, exp_rd);
                ok = 1'b0;
            end
            // Data of an x0 write is architecturally dead
            if (exp_rd != '0 && i_commit_data !== exp_data) begin
                $display("FAIL %0t: pc %h insn %h data %h, expected %h",
                         $time, pc, insn, i_commit_data, exp_data);
                ok = 1'b0;
            end
            if (exp_rd != '0) begin
                shadow[exp_rd] = exp_data;
            end
            if (ok) begin
                $display("test %0d: pc %h insn %h x%0d = %h ok",
                         committed, pc, insn, exp_rd, exp_data);
            end else begin
                $display("test %0d: pc %h insn %h failed", committed, pc, insn);
                errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            if (i_commit_valid !== 1'b0) begin
                $display("error: commit valid is not low during reset at %0t", $time);
                errors++;
            end
            if (i_insn_ready !== 1'b1) begin
                $display("error: insn ready is not high during reset at %0t", $time);
                errors++;
            end
            insn_q.delete();
            pc_q.delete();
            for (int i = 0; i < 32; i++) begin
                shadow[i] = '0;
            end
        end else begin
            // Commit first so a same-edge accept never matches itself
            if (i_commit_valid) begin
                check_commit();
            end
            if (i_insn_valid && i_insn_ready) begin
                insn_q.push_back(i_insn);
                pc_q.push_back(i_pc);
                accepted++;
            end
        end
    end

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*;;

    localparam int XLEN          = 32;
    localparam int N_INSNS       = 300;
    localparam int READY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 500;

    logic            clk;
    logic            resetn;
    logic            i_insn_valid;
    insn_t           i_insn;
    logic [XLEN-1:0] i_pc;
    logic            o_insn_ready;
    logic            o_commit_valid;
    logic [XLEN-1:0] o_commit_pc;
    reg_idx_t        o_commit_rd;
    logic [XLEN-1:0] o_commit_data;

    int   accepted;
    int   committed;
    int   chk_errors;
    int   tb_errors;
    int   seed;
    logic timed_out;

    cpu_core #(
        .XLEN (XLEN)
    ) dut_i (
        .clk            (clk),
        .resetn         (resetn),
        .i_insn_valid   (i_insn_valid),
        .i_insn         (i_insn),
        .i_pc           (i_pc),
        .o_insn_ready   (o_insn_ready),
        .o_commit_valid (o_commit_valid),
        .o_commit_pc    (o_commit_pc),
        .o_commit_rd    (o_commit_rd),
        .o_commit_data  (o_commit_data)
    );

    tb_checker #(
        .XLEN (XLEN)
    ) u_checker (
        .clk            (clk),
        .resetn         (resetn),
        .i_insn_valid   (i_insn_valid),
        .i_insn_ready   (o_insn_ready),
        .i_insn         (i_insn),
        .i_pc           (i_pc),
        .i_commit_valid (o_commit_valid),
        .i_commit_pc    (o_commit_pc),
        .i_commit_rd    (o_commit_rd),
        .i_commit_data  (o_commit_data),
        .o_accepted     (accepted),
        .o_committed    (committed),
        .o_errors       (chk_errors)
    );

    always #10 clk = ~clk;

    // Only x0..x7 are used so that dependencies come often
    function automatic insn_t make_insn(input logic [31:0] rnd);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        insn_t      insn;
        rd  = {2'b00, rnd[7:5]};
        rs1 = {2'b00, rnd[10:8]};
        rs2 = {2'b00, rnd[13:11]};
        case (rnd[4:1])
            4'd5, 4'd13: insn = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            4'd6:        insn = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            4'd7:        insn = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            4'd8:        insn = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            4'd9:        insn = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            4'd10:       insn = {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            4'd11, 4'd12: insn = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
            4'd14:       insn = {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            4'd15: begin
                // Either a load word or an AND with the SUB funct7
                if (rnd[0]) begin
                    insn = {rnd[31:20], rs1, 3'b010, rd, 7'b0000011};
                end else begin
                    insn = {7'b0100000, rs2, rs1, 3'b111, rd, 7'b0110011};
                end
            end
            default:     insn = {rnd[31:20], rs1, 3'b000, rd, 7'b0010011};
        endcase
        return insn;
    endfunction

    task automatic send_insn(input insn_t insn, input logic [XLEN-1:0] pc);
        int waited;
        i_insn_valid = 1'b1;
        i_insn       = insn;
        i_pc         = pc;
        waited       = 0;
        @(negedge clk);
        while (!o_insn_ready && !timed_out) begin
            waited++;
            if (waited > READY_TIMEOUT) begin
                $display("timeout: insn ready stayed low for %0d cycles at pc %h", waited, pc);
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
        i_insn_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (committed != accepted && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                $display("timeout: only %0d of %0d accepted instructions committed",
                         committed, accepted);
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        logic [31:0]     rnd;
        logic [XLEN-1:0] pc;
        seed         = 32'h5fe2;
        clk          = 1'b0;
        resetn       = 1'b0;
        i_insn_valid = 1'b0;
        i_insn       = '0;
        i_pc         = '0;
        timed_out    = 1'b0;
        tb_errors    = 0;
        pc           = 32'h0000_1000;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;

        for (int n = 0; n < N_INSNS && !timed_out; n++) begin
            rnd = $random(seed);
            send_insn(make_insn(rnd), pc);
            pc  = pc + 32'd4;
            rnd = $random(seed);
            if (rnd[1:0] == 2'b00) begin
                repeat (int'(rnd[3:2]) + 1) @(posedge clk);
                #1;
            end
        end

        wait_for_drain();
        // Leave room for a stray extra commit to show up
        repeat (10) @(posedge clk);
        if (!timed_out && accepted != N_INSNS) begin
            $display("error: %0d instructions sent but %0d accepted", N_INSNS, accepted);
            tb_errors++;
        end
        if (!timed_out && committed != accepted) begin
            $display("error: %0d instructions accepted but %0d commits seen",
                     accepted, committed);
            tb_errors++;
        end
        $display("summary: %0d accepted, %0d committed, %0d failed checks, %0d other errors",
                 accepted, committed, chk_errors, tb_errors);
        if (timed_out || chk_errors != 0 || tb_errors != 0) begin
            $display("** FAIL **");
        end else begin
            $display("** PASS **");
        end
        $finish;
    end

endmodule

/* src.f */
cpu_pkg.sv
insn_decoder.sv
reg_file.sv
issue_stage.sv
mul_unit.sv
commit_stage.sv
cpu_core.sv
tb_checker.sv
tb_cpu.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_cpu -o Vtb_cpu
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx '\*\* PASS \*\*' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
